// File: design/lms_data_pkg.sv
`default_nettype none

package lms_data_pkg;

    // ##################################################################
    // sample path
    // ##################################################################
    localparam int SAMPLE_W  = 14;   // signed audio sample
    localparam int TAPS      = 8;
    localparam int TAP_IDX_W = 3;

    // ##################################################################
    // weights and accumulator, two's complement fixed point
    // ##################################################################
    localparam int WEIGHT_W  = 32;   // Q16.16
    localparam int FRAC_BITS = 16;
    localparam int MU_SHIFT  = 10;   // step size 2^-10
    localparam int ACC_W     = 48;

    // the LMS increment e*r*mu lands in weight format with this left shift
    localparam int UPD_SHIFT = FRAC_BITS - MU_SHIFT;

endpackage

`default_nettype wire

// File: design/lms_frame_pkg.sv
`default_nettype none

package lms_frame_pkg;

    // ##################################################################
    // phase codes of the frame sequencer
    // ##################################################################
    localparam int PHASE_W = 3;

    localparam logic [PHASE_W-1:0] PH_IDLE   = 3'd0;   // wait for head_flag
    localparam logic [PHASE_W-1:0] PH_SHIFT  = 3'd1;
    localparam logic [PHASE_W-1:0] PH_FILTER = 3'd2;
    localparam logic [PHASE_W-1:0] PH_ERROR  = 3'd3;
    localparam logic [PHASE_W-1:0] PH_UPDATE = 3'd4;
    localparam logic [PHASE_W-1:0] PH_HOLD   = 3'd5;   // wait for head_flag low

    // ##################################################################
    // frame schedule
    // ##################################################################
    // shift + filter walk + error + update walk
    localparam int FRAME_CYCLES = 2 * lms_data_pkg::TAPS + 2;

endpackage

`default_nettype wire

// File: design/frame_sequencer.sv
`default_nettype none

module frame_sequencer (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               head_flag,
    output logic                               shift_en,
    output logic                               mac_en,
    output logic                               err_en,
    output logic                               upd_en,
    output logic [lms_data_pkg::TAP_IDX_W-1:0] tap_idx
);
    import lms_data_pkg::*;
    import lms_frame_pkg::*;

    logic [PHASE_W-1:0]   phase;
    logic [PHASE_W-1:0]   next_phase;
    logic [TAP_IDX_W-1:0] tap_cnt;
    logic                 tap_last;

    assign tap_last = (tap_cnt == TAP_IDX_W'(TAPS - 1));

    // ##################################################################
    // phase control
    // ##################################################################
    always_comb
    begin
        next_phase = phase;
        case (phase)
            PH_IDLE:   if (head_flag) next_phase = PH_SHIFT;
            PH_SHIFT:  next_phase = PH_FILTER;
            PH_FILTER: if (tap_last) next_phase = PH_ERROR;
            PH_ERROR:  next_phase = PH_UPDATE;
            PH_UPDATE: if (tap_last) next_phase = PH_HOLD;
            PH_HOLD:   if (!head_flag) next_phase = PH_IDLE;
            default:   next_phase = PH_IDLE;   // unused codes recover
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            phase <= PH_IDLE;
        else
            phase <= next_phase;
    end

    // tap index walks 0..TAPS-1 in filter and update and rests at 0 elsewhere
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            tap_cnt <= '0;
        else if (mac_en || upd_en)
            tap_cnt <= tap_last ? '0 : tap_cnt + 1'b1;
    end

    // strobes straight from the registered phase
    assign shift_en = (phase == PH_SHIFT);
    assign mac_en   = (phase == PH_FILTER);
    assign err_en   = (phase == PH_ERROR);
    assign upd_en   = (phase == PH_UPDATE);
    assign tap_idx  = tap_cnt;

    // ##################################################################
    // checks
    // ##################################################################
    // error follows the full filter walk and the last update closes the frame
    a_frame_sched : assert property (@(posedge clk) disable iff (!rstn)
        shift_en |-> ##(TAPS + 1) err_en
                     ##(FRAME_CYCLES - TAPS - 2) (upd_en && tap_last)
                     ##1 !upd_en);

endmodule

`default_nettype wire

// File: design/tap_delay_line.sv
`default_nettype none

module tap_delay_line (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic                                     shift_en,
    input  logic signed [lms_data_pkg::SAMPLE_W-1:0] sample_in,
    input  logic        [lms_data_pkg::TAP_IDX_W-1:0] tap_idx,
    output logic signed [lms_data_pkg::SAMPLE_W-1:0] ref_tap
);
    import lms_data_pkg::*;

    logic signed [SAMPLE_W-1:0] taps [TAPS];   // taps[0] is newest

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int k = 0; k < TAPS; k++)
                taps[k] <= '0;
        end
        else if (shift_en)
        begin
            taps[0] <= sample_in;
            for (int k = 1; k < TAPS; k++)
                taps[k] <= taps[k-1];   // age by one frame
        end
    end

    // single read port shared by both channels
    assign ref_tap = taps[tap_idx];

endmodule

`default_nettype wire

// File: design/lms_channel.sv
`default_nettype none

module lms_channel (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      shift_en,
    input  logic                                      mac_en,
    input  logic                                      err_en,
    input  logic                                      upd_en,
    input  logic        [lms_data_pkg::TAP_IDX_W-1:0] tap_idx,
    input  logic signed [lms_data_pkg::SAMPLE_W-1:0]  ref_tap,
    input  logic signed [lms_data_pkg::SAMPLE_W-1:0]  primary,
    output logic signed [lms_data_pkg::SAMPLE_W-1:0]  d,
    output logic signed [lms_data_pkg::WEIGHT_W-1:0]  weight0
);
    import lms_data_pkg::*;

    logic signed [WEIGHT_W-1:0] weight [TAPS];
    logic signed [ACC_W-1:0]    acc;
    logic signed [SAMPLE_W-1:0] primary_q;

    logic signed [ACC_W-1:0]    mac_prod;
    logic signed [ACC_W-1:0]    est_full;
    logic signed [SAMPLE_W-1:0] est;
    logic signed [WEIGHT_W-1:0] upd_prod;
    logic signed [WEIGHT_W-1:0] upd_inc;

    // ##################################################################
    // filter: acc = sum w[k]*r[k], one tap per cycle
    // ##################################################################
    assign mac_prod = weight[tap_idx] * ref_tap;   // full signed product

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            acc <= '0;
        else if (shift_en)
            acc <= '0;   // new frame
        else if (mac_en)
            acc <= acc + mac_prod;
    end

    // newest primary sample, taken together with the reference shift
    always_ff @(posedge clk)
    begin
        if (shift_en)
            primary_q <= primary;
    end

    // ##################################################################
    // error
    // ##################################################################
    // drop the weight fraction, keep the low sample bits
    assign est_full = acc >>> FRAC_BITS;
    assign est      = est_full[SAMPLE_W-1:0];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            d <= '0;
        else if (err_en)
            d <= primary_q - est;   // wraps to 14 bits
    end

    // ##################################################################
    // LMS weight update, w[k] += mu*e*r[k]
    // ##################################################################
    assign upd_prod = d * ref_tap;   // sign-extended to weight width
    assign upd_inc  = upd_prod <<< UPD_SHIFT;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int k = 0; k < TAPS; k++)
                weight[k] <= '0;
        end
        else if (upd_en)
        begin
            weight[tap_idx] <= weight[tap_idx] + upd_inc;   // modulo 2^32
        end
    end

    assign weight0 = weight[0];

    // accumulate and update share the weight read, never at once
    a_mac_upd_excl : assert property (@(posedge clk) disable iff (!rstn)
        !(mac_en && upd_en));

endmodule

`default_nettype wire

// File: design/noise_canceller_top.sv
`default_nettype none

module noise_canceller_top (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic                                     head_flag,
    input  logic signed [lms_data_pkg::SAMPLE_W-1:0] primary_a,
    input  logic signed [lms_data_pkg::SAMPLE_W-1:0] primary_b,
    input  logic signed [lms_data_pkg::SAMPLE_W-1:0] reference,
    output logic signed [lms_data_pkg::SAMPLE_W-1:0] dout,
    output logic signed [lms_data_pkg::WEIGHT_W-1:0] weight_probe
);
    import lms_data_pkg::*;

    logic                       shift_en;
    logic                       mac_en;
    logic                       err_en;
    logic                       upd_en;
    logic [TAP_IDX_W-1:0]       tap_idx;
    logic signed [SAMPLE_W-1:0] ref_tap;
    logic signed [SAMPLE_W-1:0] d_a;
    logic signed [SAMPLE_W-1:0] d_b;

    frame_sequencer u_seq (
        .clk       (clk),
        .rstn      (rstn),
        .head_flag (head_flag),
        .shift_en  (shift_en),
        .mac_en    (mac_en),
        .err_en    (err_en),
        .upd_en    (upd_en),
        .tap_idx   (tap_idx)
    );

    tap_delay_line u_ref_line (
        .clk       (clk),
        .rstn      (rstn),
        .shift_en  (shift_en),
        .sample_in (reference),
        .tap_idx   (tap_idx),
        .ref_tap   (ref_tap)
    );

    lms_channel chan_a (
        .clk (clk), .rstn (rstn),
        .shift_en (shift_en), .mac_en (mac_en), .err_en (err_en), .upd_en (upd_en),
        .tap_idx (tap_idx), .ref_tap (ref_tap), .primary (primary_a),
        .d (d_a), .weight0 (weight_probe)
    );

    lms_channel chan_b (
        .clk (clk), .rstn (rstn),
        .shift_en (shift_en), .mac_en (mac_en), .err_en (err_en), .upd_en (upd_en),
        .tap_idx (tap_idx), .ref_tap (ref_tap), .primary (primary_b),
        .d (d_b), .weight0 ()   // only channel A is observed
    );

    // summed error, wraps to 14 bits
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            dout <= '0;
        else
            dout <= d_a + d_b;
    end

endmodule

`default_nettype wire

// File: test/tb_noise_canceller.sv
`default_nettype none

module tb_noise_canceller;
    timeunit 1ns;
    timeprecision 100ps;

    import lms_data_pkg::*;
    import lms_frame_pkg::*;

    localparam int N_DIRECTED = 6;
    localparam int N_RANDOM   = 40;
    localparam int N_ROWS     = N_DIRECTED + N_RANDOM;

    logic                       clk = 1'b0;
    logic                       rstn = 1'b0;
    logic                       head_flag = 1'b0;
    logic signed [SAMPLE_W-1:0] primary_a = '0;
    logic signed [SAMPLE_W-1:0] primary_b = '0;
    logic signed [SAMPLE_W-1:0] reference = '0;
    logic signed [SAMPLE_W-1:0] dout;
    logic signed [WEIGHT_W-1:0] weight_probe;

    // stimulus and expected columns with one row per frame
    logic signed [SAMPLE_W-1:0] tab_pa   [N_ROWS];
    logic signed [SAMPLE_W-1:0] tab_pb   [N_ROWS];
    logic signed [SAMPLE_W-1:0] tab_ref  [N_ROWS];
    int                         tab_high [N_ROWS];
    int                         tab_gap  [N_ROWS];
    logic signed [SAMPLE_W-1:0] tab_dout [N_ROWS];
    logic signed [WEIGHT_W-1:0] tab_w0   [N_ROWS];

    // reference model state
    logic signed [SAMPLE_W-1:0] mdl_taps [TAPS];
    logic signed [WEIGHT_W-1:0] mdl_w    [2][TAPS];

    logic [31:0] lcg_state = 32'hd0b22f37;
    int          sample_errs = 0;
    int          weight_errs = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    noise_canceller_top DUT (
        .clk          (clk),
        .rstn         (rstn),
        .head_flag    (head_flag),
        .primary_a    (primary_a),
        .primary_b    (primary_b),
        .reference    (reference),
        .dout         (dout),
        .weight_probe (weight_probe)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout: the frames did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ##################################################################
    // stimulus table and LMS model
    // ##################################################################
    function automatic int rand_range(input int span);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:8] % span);
    endfunction

    task automatic set_row(input int r, input int pa, input int pb, input int rf,
                           input int high, input int gap);
        tab_pa[r]   = SAMPLE_W'(pa);
        tab_pb[r]   = SAMPLE_W'(pb);
        tab_ref[r]  = SAMPLE_W'(rf);
        tab_high[r] = high;
        tab_gap[r]  = gap;
    endtask

    task automatic build_table();
        int rv;
        int nv;
        set_row(0, 100, -50, 300, FRAME_CYCLES + 2, 3);   // weights still zero
        set_row(1, -700, 1200, -1500, FRAME_CYCLES + 2, 2);
        set_row(2, 400, 900, 2000, FRAME_CYCLES + 5, 4);
        set_row(3, 1500, -800, 1000, 4 * FRAME_CYCLES, 3);   // long head_flag still runs one frame
        set_row(4, 8191, -8192, -8192, FRAME_CYCLES + 2, 2);
        set_row(5, -8000, -7000, 8191, FRAME_CYCLES + 2, 2);   // sum wraps
        for (int r = N_DIRECTED; r < N_ROWS; r++)
        begin
            rv = rand_range(4001) - 2000;
            nv = rand_range(1001) - 500;
            // primary_a carries half the reference plus noise
            set_row(r, (rv >>> 1) + nv, rand_range(4001) - 2000, rv,
                    FRAME_CYCLES + 2 + rand_range(5), 2 + rand_range(4));
        end
        cycle_limit = 16 + 50;
        for (int r = 0; r < N_ROWS; r++)
            cycle_limit += tab_high[r] + tab_gap[r];
    endtask

    function automatic logic signed [SAMPLE_W-1:0] model_error(input int ch,
                                                               input logic signed [SAMPLE_W-1:0] x);
        logic signed [ACC_W-1:0]    acc;
        logic signed [SAMPLE_W-1:0] est;
        acc = '0;
        for (int k = 0; k < TAPS; k++)
            acc = acc + ACC_W'(mdl_w[ch][k]) * ACC_W'(mdl_taps[k]);
        est = SAMPLE_W'(acc >>> FRAC_BITS);
        return SAMPLE_W'(x - est);
    endfunction

    task automatic model_adapt(input int ch, input logic signed [SAMPLE_W-1:0] e);
        logic signed [WEIGHT_W-1:0] inc;
        for (int k = 0; k < TAPS; k++)
        begin
            inc = WEIGHT_W'(e) * WEIGHT_W'(mdl_taps[k]);
            mdl_w[ch][k] = mdl_w[ch][k] + (inc <<< (FRAC_BITS - MU_SHIFT));
        end
    endtask

    task automatic run_model();
        logic signed [SAMPLE_W-1:0] ea;
        logic signed [SAMPLE_W-1:0] eb;
        for (int k = 0; k < TAPS; k++)
        begin
            mdl_taps[k] = '0;
            mdl_w[0][k] = '0;
            mdl_w[1][k] = '0;
        end
        for (int r = 0; r < N_ROWS; r++)
        begin
            for (int k = TAPS - 1; k > 0; k--)
                mdl_taps[k] = mdl_taps[k-1];
            mdl_taps[0] = tab_ref[r];
            ea = model_error(0, tab_pa[r]);   // both errors use the old weights
            eb = model_error(1, tab_pb[r]);
            model_adapt(0, ea);
            model_adapt(1, eb);
            tab_dout[r] = ea + eb;
            tab_w0[r]   = mdl_w[0][0];
        end
    endtask

    // ##################################################################
    // compare tasks
    // ##################################################################
    task automatic check_sample(input logic signed [SAMPLE_W-1:0] got,
                                input logic signed [SAMPLE_W-1:0] exp, input string what);
        if (got !== exp)
        begin
            sample_errs++;
            $display("MISMATCH %0t ns: %s dout %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_weight(input logic signed [WEIGHT_W-1:0] got,
                                input logic signed [WEIGHT_W-1:0] exp, input string what);
        if (got !== exp)
        begin
            weight_errs++;
            $display("MISMATCH %0t ns: %s weight_probe %h, expected %h", $time, what, got, exp);
        end
    endtask

    initial
    begin
        logic signed [WEIGHT_W-1:0] first_w;
        build_table();
        run_model();
        repeat (16) @(posedge clk);
        #5 rstn = 1'b1;
        check_sample(dout, '0, "after reset");
        check_weight(weight_probe, '0, "after reset");

        for (int r = 0; r < N_ROWS; r++)
        begin
            primary_a = tab_pa[r];
            primary_b = tab_pb[r];
            reference = tab_ref[r];
            head_flag = 1'b1;
            repeat (tab_high[r]) @(posedge clk);
            #5 head_flag = 1'b0;
            check_sample(dout, tab_dout[r], $sformatf("row %0d", r));
            check_weight(weight_probe, tab_w0[r], $sformatf("row %0d", r));
            if (r == 0)
            begin
                // zero weights leave the error equal to the primary
                first_w = WEIGHT_W'(tab_pa[0]) * WEIGHT_W'(tab_ref[0]);
                check_sample(dout, SAMPLE_W'(tab_pa[0] + tab_pb[0]), "first frame sum");
                check_weight(weight_probe, first_w <<< 6, "first frame step");
            end
            repeat (tab_gap[r]) @(posedge clk);
            #5;
        end

        $display("errors: sample %0d weight %0d", sample_errs, weight_errs);
        if (sample_errs + weight_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
design/lms_data_pkg.sv
design/lms_frame_pkg.sv
design/frame_sequencer.sv
design/tap_delay_line.sv
design/lms_channel.sv
design/noise_canceller_top.sv
test/tb_noise_canceller.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_noise_canceller -Mdir obj_dir -o sim_noise_canceller

./obj_dir/sim_noise_canceller | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
